/* tb.f */
hw/DekodierPaket.sv
hw/Befehlsholer.sv
hw/Instruktionsdekodierer.sv
hw/Registersatz.sv
hw/Sprungeinheit.sv
hw/Steuerwerk.sv
hw/DekodierKern.sv
bench/DekodierKern_assertions.sv
bench/DekodierKernTb.sv

/* bench/DekodierKernTb.sv */
`timescale 1ns/1ps

module DekodierKernTb;

    localparam int AdressBreite   = 8;
    localparam int DatenBreite    = 32;
    localparam int ProgrammLaenge = 39;
    localparam int Grenze         = ProgrammLaenge * 4 + 200;
    // Path 0..7, 11, 20, 25, 26, 30..37; the halt at 38 is not output.
    localparam int PaketAnzahl    = 20;

    logic                        DekodierSignal = 1'b0;
    logic                        Reset;
    logic                        ProgrammSchreiben;
    logic [AdressBreite-1:0]     ProgrammAdresse;
    DekodierPaket::WortT         ProgrammDaten;
    logic                        Start;
    logic                        RueckschreibGueltig;
    DekodierPaket::RegNrT        RueckschreibRegister;
    logic [DatenBreite-1:0]      RueckschreibDaten;
    logic                        Bereit;
    DekodierPaket::BefehlsPaketT Befehl;
    logic                        Laeuft;
    logic                        Fertig;

    integer              Saat = 32'h6d79_ceed;
    DekodierPaket::WortT Programm [2**AdressBreite];
    DekodierPaket::WortT Schatten [64] = '{default: '0};
    DekodierPaket::WortT Abbild [64] = '{default: '0};
    int                  ModellPc = 0;
    logic                HaltErreicht = 1'b0;
    logic                Beendet = 1'b0;
    int                  FertigAnzahl = 0;
    int                  Annahmen = 0;
    int                  Zyklen = 0;

    DekodierKern #(
        .AdressBreite (AdressBreite),
        .DatenBreite  (DatenBreite)
    ) i_DekodierKern (
        .DekodierSignal       (DekodierSignal),
        .Reset                (Reset),
        .ProgrammSchreiben    (ProgrammSchreiben),
        .ProgrammAdresse      (ProgrammAdresse),
        .ProgrammDaten        (ProgrammDaten),
        .Start                (Start),
        .RueckschreibGueltig  (RueckschreibGueltig),
        .RueckschreibRegister (RueckschreibRegister),
        .RueckschreibDaten    (RueckschreibDaten),
        .Bereit               (Bereit),
        .Befehl               (Befehl),
        .Laeuft               (Laeuft),
        .Fertig               (Fertig)
    );

    always #4 DekodierSignal = !DekodierSignal;

    task automatic Abbrechen(input string Grund);
        $display("Error at %0t ns: %s", $time, Grund);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic Vergleichen(input string Name, input logic [255:0] Ist,
                               input logic [255:0] Soll);
        if (Ist !== Soll) begin
            Abbrechen($sformatf("%s is %0h, expected %0h", Name, Ist, Soll));
        end
    endtask

    function automatic DekodierPaket::WortT RTyp(input logic [4:0] Rd, input logic [4:0] Rs1,
                                                 input logic [4:0] Rs2, input logic [5:0] Fkt);
        return {6'b000000, Rd, Rs1, Rs2, 5'b00000, Fkt};
    endfunction

    function automatic DekodierPaket::WortT ITyp(input logic [5:0] Op, input logic [4:0] Rt,
                                                 input logic [4:0] Rs, input logic [15:0] Imm);
        return {Op, Rt, Rs, Imm};
    endfunction

    // ==================================================
    // Reference decode and program walk.
    // ==================================================
    function automatic DekodierPaket::BefehlsPaketT Referenz(input DekodierPaket::WortT W,
                                                             input int Adr);
        DekodierPaket::BefehlsPaketT P;
        logic [5:0]                  Op;
        logic                        Fl;
        P  = '0;
        Op = W[31:26];
        Fl = W[31:30] == 2'b00 && W[5:4] == 2'b10;
        case (W[31:30])
            2'b00: begin
                P.QuellRegister1 = {Fl, W[20:16]};
                P.QuellRegister2 = {Fl, W[15:11]};
                P.ZielRegister   = {Fl, W[25:21]};
                P.FunktionsCode  = W[5:0];
            end
            2'b01: begin
                P.IDaten                = W[25:0];
                P.GrosserImmediateAktiv = 1'b1;
            end
            default: begin
                P.QuellRegister1        = {1'b0, W[20:16]};
                P.ZielRegister          = {Op == DekodierPaket::OpFloatLaden, W[25:21]};
                P.IDaten                = 26'($signed(W[15:0]));
                P.KleinerImmediateAktiv = 1'b1;
                if (Op == DekodierPaket::OpSpeichern) begin
                    P.QuellRegister2 = {1'b0, W[25:21]};
                end
                // Memory and jump opcodes 101010 to 101111 carry no function code.
                if (Op[5:3] != 3'b101 || Op[2:0] < 3'd2) begin
                    P.FunktionsCode = {1'b0, W[30:26]};
                end
            end
        endcase
        P.JALBefehl               = Op == DekodierPaket::OpJal;
        P.AbsoluterSprung         = Op == DekodierPaket::OpAbsSprung;
        P.BedingterSprungBefehl   = Op == DekodierPaket::OpBedSprung;
        P.RelativerSprung         = P.JALBefehl || P.BedingterSprungBefehl
                                    || Op == DekodierPaket::OpGrossSprung;
        P.UnbedingterSprungBefehl = P.JALBefehl || P.AbsoluterSprung
                                    || Op == DekodierPaket::OpGrossSprung;
        P.FloatBefehl             = Fl || Op == DekodierPaket::OpFloatLaden;
        P.LoadBefehl              = W[31:27] == DekodierPaket::OpLaden;
        P.StoreBefehl             = Op == DekodierPaket::OpSpeichern;
        P.Operand1                = Abbild[P.QuellRegister1];
        P.Operand2                = Abbild[P.QuellRegister2];
        P.Adresse                 = 32'(Adr);
        P.RueckkehrAdresse        = 32'(Adr) + 32'd1;
        P.Gueltig                 = 1'b1;
        return P;
    endfunction

    function automatic int Folgeadresse(input DekodierPaket::BefehlsPaketT P);
        logic [31:0] Ziel;
        Ziel = P.Adresse + 32'd1;
        if (P.UnbedingterSprungBefehl || (P.BedingterSprungBefehl && P.Operand1 == '0)) begin
            if (P.AbsoluterSprung) begin
                Ziel = 32'(P.IDaten);
            end else begin
                Ziel = P.Adresse + 32'd1 + 32'($signed(P.IDaten));
            end
        end
        return int'(Ziel) & (2**AdressBreite - 1);
    endfunction

    // Samples pre-edge values, so it sees what the DUT sees at this edge.
    always @(posedge DekodierSignal) begin
        DekodierPaket::BefehlsPaketT Soll;
        if (!Reset) begin
            if (Befehl.Gueltig && Bereit) begin
                if (HaltErreicht) begin
                    Abbrechen("a packet was output after the halt");
                end
                Soll = Referenz(Programm[ModellPc], ModellPc);
                Vergleichen("Befehl.Adresse", Befehl.Adresse, Soll.Adresse);
                Vergleichen("Befehl", Befehl, Soll);
                ModellPc     = Folgeadresse(Soll);
                HaltErreicht = Programm[ModellPc][31:26] == DekodierPaket::OpHalt;
                Annahmen++;
            end
            if (Fertig) begin
                FertigAnzahl++;
                if (!HaltErreicht) begin
                    Abbrechen("Fertig pulsed before the halt was reached");
                end
                Beendet <= 1'b1;
            end
            if (RueckschreibGueltig && RueckschreibRegister != 6'd0) begin
                Schatten[RueckschreibRegister] = RueckschreibDaten;
            end
            // The output register loads here, with forwarded register values.
            if (Bereit || !Befehl.Gueltig) begin
                Abbild = Schatten;
            end
        end
    end

    always @(posedge DekodierSignal) begin
        Zyklen++;
        if (i_DekodierKern.i_Protokoll.Fehlerzahl != 0) begin
            Abbrechen("a protocol assertion on the DUT outputs failed");
        end
        if (Zyklen >= Grenze) begin
            Abbrechen($sformatf("timeout, the run did not end within %0d cycles", Grenze));
        end
    end

    initial begin
        logic [31:0] Zufall;
        Reset                = 1'b1;
        ProgrammSchreiben    = 1'b0;
        ProgrammAdresse      = '0;
        ProgrammDaten        = '0;
        Start                = 1'b0;
        RueckschreibGueltig  = 1'b0;
        RueckschreibRegister = '0;
        RueckschreibDaten    = '0;
        Bereit               = 1'b1;

        for (int a = 0; a < 2**AdressBreite; a++) begin
            Programm[a] = {6'b000001, 2'b00, 8'(a), 8'(a), 8'(a)};
        end
        Programm[0]  = RTyp(5'd3, 5'd1, 5'd2, 6'h0a);
        Programm[1]  = RTyp(5'd4, 5'd5, 5'd6, 6'h2c);
        Programm[2]  = ITyp({DekodierPaket::OpLaden, 1'b0}, 5'd7, 5'd1, 16'hfff0);
        Programm[3]  = ITyp(DekodierPaket::OpFloatLaden, 5'd8, 5'd2, 16'h0123);
        Programm[4]  = ITyp(DekodierPaket::OpSpeichern, 5'd9, 5'd0, 16'h8001);
        Programm[5]  = ITyp(6'b100011, 5'd10, 5'd9, 16'h7fff);
        Programm[6]  = {6'b010011, 26'h2abcdef};
        Programm[7]  = {DekodierPaket::OpGrossSprung, 26'd3};
        Programm[11] = ITyp(DekodierPaket::OpAbsSprung, 5'd0, 5'd0, 16'd20);
        Programm[20] = ITyp(DekodierPaket::OpJal, 5'd31, 5'd1, 16'd4);
        Programm[25] = ITyp(DekodierPaket::OpBedSprung, 5'd0, 5'd11, 16'd5);
        Programm[26] = ITyp(DekodierPaket::OpBedSprung, 5'd0, 5'd0, 16'd3);
        for (int i = 30; i < 38; i++) begin
            Programm[i] = RTyp(5'(i), 5'(i % 6), 5'(i % 5 + 1), (i % 2) ? 6'h23 : 6'h05);
        end
        Programm[38] = {DekodierPaket::OpHalt, 26'd0};

        repeat (16) @(posedge DekodierSignal);
        Reset <= 1'b0;

        for (int a = 0; a < ProgrammLaenge + 3; a++) begin
            @(posedge DekodierSignal);
            ProgrammSchreiben <= 1'b1;
            ProgrammAdresse   <= 8'(a);
            ProgrammDaten     <= Programm[a];
        end
        // Preload every register, register 0 included.
        for (int r = 0; r < 64; r++) begin
            @(posedge DekodierSignal);
            ProgrammSchreiben    <= 1'b0;
            RueckschreibGueltig  <= 1'b1;
            RueckschreibRegister <= 6'(r);
            RueckschreibDaten    <= $random(Saat);
        end
        @(posedge DekodierSignal);
        RueckschreibGueltig <= 1'b0;
        Start               <= 1'b1;
        @(posedge DekodierSignal);
        Start <= 1'b0;

        // Word 0 sits in the decoder during the cycle after the second edge,
        // so a write to its first source register then is forwarded to Operand1.
        repeat (2) @(posedge DekodierSignal);
        RueckschreibGueltig  <= 1'b1;
        RueckschreibRegister <= 6'd1;
        RueckschreibDaten    <= $random(Saat);

        while (!Beendet) begin
            @(posedge DekodierSignal);
            Zufall = $random(Saat);
            Bereit               <= Zufall[7:6] != 2'b00;
            RueckschreibGueltig  <= Zufall[0];
            RueckschreibRegister <= {Zufall[1], 1'b0, Zufall[5:2]};
            RueckschreibDaten    <= $random(Saat);
        end
        @(posedge DekodierSignal);
        Bereit              <= 1'b1;
        RueckschreibGueltig <= 1'b0;
        repeat (4) @(posedge DekodierSignal);

        Vergleichen("FertigAnzahl", FertigAnzahl, 1);
        Vergleichen("Laeuft", Laeuft, 1'b0);
        Vergleichen("Annahmen", Annahmen, PaketAnzahl);
        if (i_DekodierKern.i_Protokoll.Fehlerzahl == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* bench/DekodierKern_assertions.sv */
`timescale 1ns/1ps

module DekodierKern_assertions (
    input logic                        DekodierSignal,
    input logic                        Reset,
    input logic                        Bereit,
    input DekodierPaket::BefehlsPaketT Befehl,
    input logic                        Laeuft,
    input logic                        Fertig
);

    int Fehlerzahl = 0;

    // A packet held by the consumer must not change.
    BefehlStabil: assert property (@(posedge DekodierSignal) disable iff (Reset)
        Befehl.Gueltig && !Bereit |=> $stable(Befehl))
    else begin
        Fehlerzahl++;
        $error("Befehl changed while held by the consumer");
    end

    FertigPuls: assert property (@(posedge DekodierSignal) disable iff (Reset)
        Fertig |=> !Fertig)
    else begin
        Fehlerzahl++;
        $error("Fertig is longer than one cycle");
    end

    // Output only while running.
    AusgabeNurImLauf: assert property (@(posedge DekodierSignal) disable iff (Reset)
        !Laeuft |-> !Befehl.Gueltig)
    else begin
        Fehlerzahl++;
        $error("valid output while Laeuft is low");
    end

endmodule

bind DekodierKern DekodierKern_assertions i_Protokoll (
    .DekodierSignal (DekodierSignal),
    .Reset          (Reset),
    .Bereit         (Bereit),
    .Befehl         (Befehl),
    .Laeuft         (Laeuft),
    .Fertig         (Fertig)
);

/* hw/DekodierKern.sv */
`timescale 1ns/1ps

module DekodierKern #(
    parameter int AdressBreite = 8,
    parameter int DatenBreite  = 32
) (
    input  logic                       DekodierSignal,
    input  logic                       Reset,
    input  logic                       ProgrammSchreiben,
    input  logic [AdressBreite-1:0]    ProgrammAdresse,
    input  DekodierPaket::WortT        ProgrammDaten,
    input  logic                       Start,
    input  logic                       RueckschreibGueltig,
    input  DekodierPaket::RegNrT       RueckschreibRegister,
    input  logic [DatenBreite-1:0]     RueckschreibDaten,
    input  logic                       Bereit,
    output DekodierPaket::BefehlsPaketT Befehl,
    output logic                       Laeuft,
    output logic                       Fertig
);

    DekodierPaket::HolPaketT     Geholt;
    DekodierPaket::DekodiertT    Dekodiert;
    DekodierPaket::WortT         DekAdresse;
    DekodierPaket::BefehlsPaketT Neu;
    DekodierPaket::BefehlsPaketT Nutzlast;
    logic [DatenBreite-1:0]      Wert1;
    logic [DatenBreite-1:0]      Wert2;
    logic [AdressBreite-1:0]     SprungZiel;
    logic                        SprungGenommen;
    logic                        Holen;
    logic                        Weiter;
    logic                        Spuelen;
    logic                        StartSetzen;
    logic                        AusgabeGueltig;

    Steuerwerk i_Steuerwerk (
        .DekodierSignal (DekodierSignal),
        .Reset          (Reset),
        .Start          (Start),
        .HaltErkannt    (Dekodiert.Gueltig && Dekodiert.Halt),
        .SprungGenommen (SprungGenommen),
        .Bereit         (Bereit),
        .AusgabeGueltig (AusgabeGueltig),
        .Holen          (Holen),
        .Weiter         (Weiter),
        .Spuelen        (Spuelen),
        .StartSetzen    (StartSetzen),
        .Laeuft         (Laeuft),
        .Fertig         (Fertig)
    );

    // Program load is locked out while running.
    Befehlsholer #(.AdressBreite(AdressBreite)) i_Befehlsholer (
        .DekodierSignal    (DekodierSignal),
        .Reset             (Reset),
        .ProgrammSchreiben (ProgrammSchreiben && !Laeuft),
        .ProgrammAdresse   (ProgrammAdresse),
        .ProgrammDaten     (ProgrammDaten),
        .StartSetzen       (StartSetzen),
        .Holen             (Holen),
        .Spuelen           (Spuelen),
        .SprungGenommen    (SprungGenommen),
        .SprungZiel        (SprungZiel),
        .Geholt            (Geholt)
    );

    Instruktionsdekodierer i_Instruktionsdekodierer (
        .DekodierSignal (DekodierSignal),
        .Reset          (Reset),
        .Geholt         (Geholt),
        .Weiter         (Weiter),
        .Spuelen        (Spuelen),
        .Dekodiert      (Dekodiert),
        .Adresse        (DekAdresse)
    );

    Registersatz #(.DatenBreite(DatenBreite)) i_Registersatz (
        .DekodierSignal (DekodierSignal),
        .Reset          (Reset),
        .LeseNr1        (Dekodiert.QuellRegister1),
        .LeseNr2        (Dekodiert.QuellRegister2),
        .SchreibGueltig (RueckschreibGueltig),
        .SchreibNr      (RueckschreibRegister),
        .SchreibDaten   (RueckschreibDaten),
        .Wert1          (Wert1),
        .Wert2          (Wert2)
    );

    Sprungeinheit #(.AdressBreite(AdressBreite)) i_Sprungeinheit (
        .Dekodiert      (Dekodiert),
        .Adresse        (DekAdresse),
        .Operand1       (Wert1),
        .SprungGenommen (SprungGenommen),
        .SprungZiel     (SprungZiel)
    );

    // ==================================================
    // Output register.
    // ==================================================
    always_comb begin
        Neu.QuellRegister1          = Dekodiert.QuellRegister1;
        Neu.QuellRegister2          = Dekodiert.QuellRegister2;
        Neu.ZielRegister            = Dekodiert.ZielRegister;
        Neu.IDaten                  = Dekodiert.IDaten;
        Neu.KleinerImmediateAktiv   = Dekodiert.KleinerImmediateAktiv;
        Neu.GrosserImmediateAktiv   = Dekodiert.GrosserImmediateAktiv;
        Neu.FunktionsCode           = Dekodiert.FunktionsCode;
        Neu.JALBefehl               = Dekodiert.JALBefehl;
        Neu.RelativerSprung         = Dekodiert.RelativerSprung;
        Neu.AbsoluterSprung         = Dekodiert.AbsoluterSprung;
        Neu.FloatBefehl             = Dekodiert.FloatBefehl;
        Neu.LoadBefehl              = Dekodiert.LoadBefehl;
        Neu.StoreBefehl             = Dekodiert.StoreBefehl;
        Neu.UnbedingterSprungBefehl = Dekodiert.UnbedingterSprungBefehl;
        Neu.BedingterSprungBefehl   = Dekodiert.BedingterSprungBefehl;
        Neu.Operand1                = Wert1;
        Neu.Operand2                = Wert2;
        Neu.Adresse                 = DekAdresse;
        Neu.RueckkehrAdresse        = DekAdresse + 32'd1;
        Neu.Gueltig                 = Dekodiert.Gueltig;
    end

    // The halt itself never leaves the core.
    always_ff @(posedge DekodierSignal or posedge Reset) begin
        if (Reset) begin
            AusgabeGueltig <= 1'b0;
        end else if (Weiter) begin
            AusgabeGueltig <= Dekodiert.Gueltig && !Dekodiert.Halt;
        end
    end

    always_ff @(posedge DekodierSignal) begin
        if (Weiter) begin
            Nutzlast <= Neu;
        end
    end

    always_comb begin
        Befehl         = Nutzlast;
        Befehl.Gueltig = AusgabeGueltig;
    end

endmodule

/* hw/Steuerwerk.sv */
`timescale 1ns/1ps

module Steuerwerk (
    input  logic DekodierSignal,
    input  logic Reset,
    input  logic Start,
    input  logic HaltErkannt,
    input  logic SprungGenommen,
    input  logic Bereit,
    input  logic AusgabeGueltig,
    output logic Holen,
    output logic Weiter,
    output logic Spuelen,
    output logic StartSetzen,
    output logic Laeuft,
    output logic Fertig
);

    typedef enum logic [1:0] {
        Ruhe,
        Lauf,
        Leeren
    } ZustandT;

    ZustandT Zustand;
    ZustandT Naechster;

    // ==================================================
    // Pipeline control.
    // ==================================================
    assign Weiter      = Bereit || !AusgabeGueltig;
    assign Holen       = Weiter && Zustand == Lauf;
    assign Spuelen     = Weiter && (SprungGenommen || HaltErkannt);
    assign StartSetzen = Start && Zustand == Ruhe;

    assign Laeuft = Zustand != Ruhe;
    // Last cycle of the run, once the output register is empty.
    assign Fertig = Zustand == Leeren && !AusgabeGueltig;

    always_comb begin
        Naechster = Zustand;
        case (Zustand)
            Ruhe: begin
                if (Start) begin
                    Naechster = Lauf;
                end
            end
            Lauf: begin
                if (HaltErkannt && Weiter) begin
                    Naechster = Leeren;
                end
            end
            Leeren: begin
                if (!AusgabeGueltig) begin
                    Naechster = Ruhe;
                end
            end
            default: begin
                Naechster = Ruhe;
            end
        endcase
    end

    always_ff @(posedge DekodierSignal or posedge Reset) begin
        if (Reset) begin
            Zustand <= Ruhe;
        end else begin
            Zustand <= Naechster;
        end
    end

endmodule

/* hw/Sprungeinheit.sv */
`timescale 1ns/1ps

module Sprungeinheit #(
    parameter int AdressBreite = 8
) (
    input  DekodierPaket::DekodiertT Dekodiert,
    input  DekodierPaket::WortT      Adresse,
    input  DekodierPaket::WortT      Operand1,
    output logic                     SprungGenommen,
    output logic [AdressBreite-1:0]  SprungZiel
);

    DekodierPaket::WortT Versatz;
    DekodierPaket::WortT RelativZiel;
    logic                Bedingung;

    assign Versatz     = {{6{Dekodiert.IDaten[25]}}, Dekodiert.IDaten};
    assign RelativZiel = Adresse + 32'd1 + Versatz;

    // Conditional jumps test Operand1 for zero.
    assign Bedingung = Dekodiert.BedingterSprungBefehl && Operand1 == '0;

    assign SprungGenommen = Dekodiert.Gueltig
                            && (Dekodiert.UnbedingterSprungBefehl || Bedingung);

    assign SprungZiel = Dekodiert.AbsoluterSprung ? Dekodiert.IDaten[AdressBreite-1:0]
                                                  : RelativZiel[AdressBreite-1:0];

endmodule

/* hw/Registersatz.sv */
`timescale 1ns/1ps

module Registersatz #(
    parameter int DatenBreite = 32
) (
    input  logic                   DekodierSignal,
    input  logic                   Reset,
    input  DekodierPaket::RegNrT   LeseNr1,
    input  DekodierPaket::RegNrT   LeseNr2,
    input  logic                   SchreibGueltig,
    input  DekodierPaket::RegNrT   SchreibNr,
    input  logic [DatenBreite-1:0] SchreibDaten,
    output logic [DatenBreite-1:0] Wert1,
    output logic [DatenBreite-1:0] Wert2
);

    // Entries 0..31 are integer, 32..63 float.
    logic [DatenBreite-1:0] Zellen [64];

    always_ff @(posedge DekodierSignal or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < 64; i++) begin
                Zellen[i] <= '0;
            end
        end else if (SchreibGueltig && SchreibNr != 6'd0) begin
            Zellen[SchreibNr] <= SchreibDaten;
        end
    end

    // Integer register 0 is hardwired, a same-cycle write is forwarded.
    function automatic logic [DatenBreite-1:0] Lesen(input DekodierPaket::RegNrT Nr);
        if (Nr == 6'd0) begin
            return '0;
        end
        if (SchreibGueltig && SchreibNr == Nr) begin
            return SchreibDaten;
        end
        return Zellen[Nr];
    endfunction

    always_comb begin
        Wert1 = Lesen(LeseNr1);
        Wert2 = Lesen(LeseNr2);
    end

endmodule

/* hw/Instruktionsdekodierer.sv */
`timescale 1ns/1ps

module Instruktionsdekodierer (
    input  logic                     DekodierSignal,
    input  logic                     Reset,
    input  DekodierPaket::HolPaketT  Geholt,
    input  logic                     Weiter,
    input  logic                     Spuelen,
    output DekodierPaket::DekodiertT Dekodiert,
    output DekodierPaket::WortT      Adresse
);

    DekodierPaket::WortT AktuellerBefehl;
    logic                Gueltig;
    logic [5:0]          Opcode;
    logic                RegKlasse;
    logic                FloatReg;

    always_ff @(posedge DekodierSignal or posedge Reset) begin
        if (Reset) begin
            AktuellerBefehl <= '0;
            Gueltig         <= 1'b0;
        end else if (Weiter) begin
            AktuellerBefehl <= Geholt.Wort;
            Gueltig         <= Geholt.Gueltig && !Spuelen;
        end
    end

    always_ff @(posedge DekodierSignal) begin
        if (Weiter) begin
            Adresse <= Geholt.Adresse;
        end
    end

    assign Opcode    = AktuellerBefehl[31:26];
    assign RegKlasse = AktuellerBefehl[31:30] == 2'b00;
    // Function bits 5:4 equal to 10 select the float bank.
    assign FloatReg  = RegKlasse && AktuellerBefehl[5:4] == 2'b10;

    // ==================================================
    // Field extraction.
    // ==================================================
    always_comb begin
        Dekodiert = '0;

        if (RegKlasse) begin
            Dekodiert.QuellRegister1 = {FloatReg, AktuellerBefehl[20:16]};
            Dekodiert.QuellRegister2 = {FloatReg, AktuellerBefehl[15:11]};
            Dekodiert.ZielRegister   = {FloatReg, AktuellerBefehl[25:21]};
        end else if (AktuellerBefehl[31]) begin
            Dekodiert.QuellRegister1 = {1'b0, AktuellerBefehl[20:16]};
            // Only a store reads its second source from bits 25:21.
            if (Opcode == DekodierPaket::OpSpeichern) begin
                Dekodiert.QuellRegister2 = {1'b0, AktuellerBefehl[25:21]};
            end
            Dekodiert.ZielRegister = {Opcode == DekodierPaket::OpFloatLaden,
                                      AktuellerBefehl[25:21]};
        end

        if (AktuellerBefehl[31:30] == 2'b01) begin
            Dekodiert.IDaten = AktuellerBefehl[25:0];
        end else if (AktuellerBefehl[31]) begin
            Dekodiert.IDaten = {{10{AktuellerBefehl[15]}}, AktuellerBefehl[15:0]};
        end

        Dekodiert.KleinerImmediateAktiv = AktuellerBefehl[31];
        Dekodiert.GrosserImmediateAktiv = AktuellerBefehl[31:30] == 2'b01;

        if (RegKlasse) begin
            Dekodiert.FunktionsCode = AktuellerBefehl[5:0];
        end else if (AktuellerBefehl[31:30] == 2'b01
                     || (Opcode >= 6'b101010 && Opcode <= 6'b101111)) begin
            Dekodiert.FunktionsCode = 6'b0;
        end else begin
            Dekodiert.FunktionsCode = {1'b0, AktuellerBefehl[30:26]};
        end

        // Class flags.
        Dekodiert.JALBefehl       = Opcode == DekodierPaket::OpJal;
        Dekodiert.RelativerSprung = Opcode == DekodierPaket::OpJal
                                    || Opcode == DekodierPaket::OpGrossSprung
                                    || Opcode == DekodierPaket::OpBedSprung;
        Dekodiert.AbsoluterSprung = Opcode == DekodierPaket::OpAbsSprung;
        Dekodiert.FloatBefehl     = FloatReg || Opcode == DekodierPaket::OpFloatLaden;
        Dekodiert.LoadBefehl      = AktuellerBefehl[31:27] == DekodierPaket::OpLaden;
        Dekodiert.StoreBefehl     = Opcode == DekodierPaket::OpSpeichern;
        Dekodiert.UnbedingterSprungBefehl = Opcode == DekodierPaket::OpAbsSprung
                                            || Opcode == DekodierPaket::OpJal
                                            || Opcode == DekodierPaket::OpGrossSprung;
        Dekodiert.BedingterSprungBefehl   = Opcode == DekodierPaket::OpBedSprung;
        Dekodiert.Halt    = Opcode == DekodierPaket::OpHalt;
        Dekodiert.Gueltig = Gueltig;
    end

endmodule

/* hw/Befehlsholer.sv */
`timescale 1ns/1ps

module Befehlsholer #(
    parameter int AdressBreite = 8
) (
    input  logic                    DekodierSignal,
    input  logic                    Reset,
    input  logic                    ProgrammSchreiben,
    input  logic [AdressBreite-1:0] ProgrammAdresse,
    input  DekodierPaket::WortT     ProgrammDaten,
    input  logic                    StartSetzen,
    input  logic                    Holen,
    input  logic                    Spuelen,
    input  logic                    SprungGenommen,
    input  logic [AdressBreite-1:0] SprungZiel,
    output DekodierPaket::HolPaketT Geholt
);

    DekodierPaket::WortT     Speicher [2**AdressBreite];
    logic [AdressBreite-1:0] Zaehler;
    DekodierPaket::WortT     GeholtWort;
    DekodierPaket::WortT     GeholtAdresse;
    logic                    GeholtGueltig;

    always_ff @(posedge DekodierSignal) begin
        if (ProgrammSchreiben) begin
            Speicher[ProgrammAdresse] <= ProgrammDaten;
        end
    end

    // A taken jump only counts when the pipeline advances.
    always_ff @(posedge DekodierSignal or posedge Reset) begin
        if (Reset) begin
            Zaehler <= '0;
        end else if (StartSetzen) begin
            Zaehler <= '0;
        end else if (Spuelen && SprungGenommen) begin
            Zaehler <= SprungZiel;
        end else if (Holen) begin
            Zaehler <= Zaehler + 1'b1;
        end
    end

    always_ff @(posedge DekodierSignal or posedge Reset) begin
        if (Reset) begin
            GeholtGueltig <= 1'b0;
        end else if (Holen) begin
            GeholtGueltig <= !Spuelen;
        end else if (Spuelen) begin
            GeholtGueltig <= 1'b0;
        end
    end

    always_ff @(posedge DekodierSignal) begin
        if (Holen) begin
            GeholtWort    <= Speicher[Zaehler];
            GeholtAdresse <= 32'(Zaehler);
        end
    end

    always_comb begin
        Geholt.Wort    = GeholtWort;
        Geholt.Adresse = GeholtAdresse;
        Geholt.Gueltig = GeholtGueltig;
    end

endmodule

/* hw/DekodierPaket.sv */
package DekodierPaket;

    localparam int WortBreite = 32;

    typedef logic [WortBreite-1:0] WortT;

    // Bit 5 selects the float bank.
    typedef logic [5:0] RegNrT;

    // ==================================================
    // Opcodes in bits 31:26.
    // ==================================================
    localparam logic [4:0] OpLaden       = 5'b10101;
    localparam logic [5:0] OpSpeichern   = 6'b101100;
    localparam logic [5:0] OpFloatLaden  = 6'b101011;
    localparam logic [5:0] OpAbsSprung   = 6'b101101;
    localparam logic [5:0] OpBedSprung   = 6'b101110;
    localparam logic [5:0] OpJal         = 6'b101111;
    localparam logic [5:0] OpGrossSprung = 6'b010000;
    localparam logic [5:0] OpHalt        = 6'b011111;

    typedef struct packed {
        RegNrT       QuellRegister1;
        RegNrT       QuellRegister2;
        RegNrT       ZielRegister;
        logic [25:0] IDaten;
        logic        KleinerImmediateAktiv;
        logic        GrosserImmediateAktiv;
        logic [5:0]  FunktionsCode;
        logic        JALBefehl;
        logic        RelativerSprung;
        logic        AbsoluterSprung;
        logic        FloatBefehl;
        logic        LoadBefehl;
        logic        StoreBefehl;
        logic        UnbedingterSprungBefehl;
        logic        BedingterSprungBefehl;
        logic        Halt;
        logic        Gueltig;
    } DekodiertT;

    typedef struct packed {
        WortT Wort;
        WortT Adresse;
        logic Gueltig;
    } HolPaketT;

    typedef struct packed {
        RegNrT       QuellRegister1;
        RegNrT       QuellRegister2;
        RegNrT       ZielRegister;
        logic [25:0] IDaten;
        logic        KleinerImmediateAktiv;
        logic        GrosserImmediateAktiv;
        logic [5:0]  FunktionsCode;
        logic        JALBefehl;
        logic        RelativerSprung;
        logic        AbsoluterSprung;
        logic        FloatBefehl;
        logic        LoadBefehl;
        logic        StoreBefehl;
        logic        UnbedingterSprungBefehl;
        logic        BedingterSprungBefehl;
        WortT        Operand1;
        WortT        Operand2;
        WortT        Adresse;
        WortT        RueckkehrAdresse;
        logic        Gueltig;
    } BefehlsPaketT;

endpackage
